//--- design/obj_pkg.sv
// Shared sizes, encodings and bundles for the sprite line renderer.
// Imported by every RTL block and by the testbench.
`default_nettype none

package obj_pkg;

    localparam int num_obj     = 64;
    localparam int entry_bytes = 5;
    localparam int attr_aw     = 9;    // byte address into the entry table
    localparam int attr_bytes  = num_obj * entry_bytes;
    localparam int line_w      = 512;  // pixels per buffer half
    localparam int rom_aw      = 18;
    localparam int code_w      = 14;

    // byte index inside one table entry
    localparam logic [2:0] byte_code_lo = 3'd0;  // code 9..2
    localparam logic [2:0] byte_code_hi = 3'd1;  // code 11..10, palette
    localparam logic [2:0] byte_ypos    = 3'd2;
    localparam logic [2:0] byte_xpos    = 3'd3;
    localparam logic [2:0] byte_attr    = 3'd4;  // x8, size, flips, code 13..12

    // control register map
    localparam logic [1:0] reg_enable  = 2'd0;
    localparam logic [1:0] reg_count   = 2'd1;
    localparam logic [1:0] reg_hoff_lo = 2'd2;
    localparam logic [1:0] reg_hoff_hi = 2'd3;

    typedef enum logic [1:0] {
        size_8  = 2'd0,
        size_16 = 2'd1,
        size_32 = 2'd2
    } obj_size_e;

    typedef enum logic [3:0] {
        st_idle, st_size, st_ypos, st_code, st_colour,
        st_xpos, st_fetch, st_dump, st_step, st_next
    } draw_state_e;

    typedef struct packed {
        logic       enable;
        logic [6:0] obj_count;  // 0 to 64
        logic [8:0] hoffset;
    } obj_cfg_t;

    typedef struct packed {
        logic       we;
        logic       half;
        logic [8:0] addr;
        logic [7:0] data;       // palette in 7..4, pixel in 3..0
    } line_wr_t;

    typedef struct packed {
        logic       we;
        logic [8:0] addr;
        logic [7:0] data;
    } cpu_wr_t;

endpackage

`default_nettype wire

//--- design/obj_attr_ram.sv
// Sprite entry table, five bytes per entry.
// The CPU writes bytes at any time, and the draw engine reads them
// back with one cycle of latency.
`timescale 1ns/1ps
`default_nettype none

module obj_attr_ram
    import obj_pkg::*;
(
    input  wire logic               clk,
    input  wire cpu_wr_t            attr_wr,
    input  wire logic [attr_aw-1:0] scan_addr,
    output logic [7:0]              scan_data
);

    logic [7:0] mem [attr_bytes];

    // cpu side, writes past the table are dropped
    always_ff @(posedge clk) begin
        if (attr_wr.we && attr_wr.addr < attr_aw'(attr_bytes)) begin
            mem[attr_wr.addr] <= attr_wr.data;
        end
    end

    // engine side
    always_ff @(posedge clk) begin
        scan_data <= mem[scan_addr];  // valid one cycle after the address
    end

endmodule

`default_nettype wire

//--- design/obj_ctrl_regs.sv
// Four byte-wide control registers written from the CPU port.
// They form the config bundle that the draw engine samples at line start.
`timescale 1ns/1ps
`default_nettype none

module obj_ctrl_regs
    import obj_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire cpu_wr_t reg_wr,
    output obj_cfg_t     cfg
);

    logic       reg_sel;
    logic [6:0] count_in;

    assign reg_sel = reg_wr.we && reg_wr.addr[8:2] == 7'd0;  // only 0..3 decode

    // table holds 64 entries at most
    assign count_in = (reg_wr.data > 8'(num_obj)) ? 7'(num_obj) : reg_wr.data[6:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.enable    <= 1'b0;
            cfg.obj_count <= 7'(num_obj);
            cfg.hoffset   <= 9'd0;
        end else if (reg_sel) begin
            case (reg_wr.addr[1:0])
                reg_enable: begin
                    cfg.enable <= reg_wr.data[0];
                end
                reg_count: begin
                    cfg.obj_count <= count_in;
                end
                reg_hoff_lo: begin
                    cfg.hoffset[7:0] <= reg_wr.data;
                end
                reg_hoff_hi: begin
                    cfg.hoffset[8] <= reg_wr.data[0];
                end
                default: begin
                    cfg.enable <= cfg.enable;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/obj_line_draw.sv
// Per-line sprite engine. On each line start it scans the entry table,
// fetches graphics words for the sprites that cover vrender and writes
// their pixels into the line buffer half being drawn.
`timescale 1ns/1ps
`default_nettype none

module obj_line_draw
    import obj_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               hb,
    input  wire logic               vb,
    input  wire logic [8:0]         vrender,
    input  wire obj_cfg_t           cfg,
    output logic [attr_aw-1:0]      scan_addr,
    input  wire logic [7:0]         scan_data,
    output logic                    rom_cs,
    output logic [rom_aw-1:0]       rom_addr,
    input  wire logic               rom_ok,
    input  wire logic [15:0]        rom_data,
    output line_wr_t                line_wr,
    output logic                    draw_half,
    output logic                    done
);

    draw_state_e        state;
    obj_cfg_t           cfg_q;      // frozen for the whole line
    logic               hb_l;
    logic               line_start;
    logic [6:0]         idx;        // entry being handled
    logic [attr_aw-1:0] base;       // byte address of that entry
    logic [2:0]         byte_sel;

    obj_size_e          size_q;
    logic               hflip_q;
    logic               vflip_q;
    logic               x8_q;
    logic [code_w-1:0]  code_q;
    logic [3:0]         pal_q;
    logic [4:0]         row_q;      // row inside the sprite, flip applied

    logic [8:0]         xpos;
    logic [15:0]        pix_data;
    logic [2:0]         word_cnt;   // half-word position, left to right
    logic [1:0]         nib_cnt;
    logic               line_we;
    logic [8:0]         wr_addr;
    logic [7:0]         wr_data;

    logic [4:0]         height_m1;
    logic [2:0]         last_word;
    logic [9:0]         y_end;
    logic [8:0]         row_diff;
    logic               miss;

    assign line_start = hb && !hb_l && vb;

    // address is presented one state ahead of the byte being used
    always_comb begin
        case (state)
            st_size:   byte_sel = byte_ypos;
            st_ypos:   byte_sel = byte_code_lo;
            st_code:   byte_sel = byte_code_hi;
            st_colour: byte_sel = byte_xpos;
            st_xpos:   byte_sel = byte_xpos;
            default:   byte_sel = byte_attr;
        endcase
    end

    assign scan_addr = base + attr_aw'(byte_sel);

    always_comb begin
        case (size_q)
            size_16: begin
                height_m1 = 5'd15;
                last_word = 3'd3;
            end
            size_32: begin
                height_m1 = 5'd31;
                last_word = 3'd7;
            end
            default: begin
                height_m1 = 5'd7;
                last_word = 3'd1;
            end
        endcase
    end

    // y range test against the byte arriving in st_ypos
    assign y_end    = {2'b00, scan_data} + 10'(height_m1) + 10'd1;
    assign row_diff = vrender - {1'b0, scan_data};
    assign miss     = ({1'b0, vrender} < {2'b00, scan_data}) || ({1'b0, vrender} >= y_end);

    // ROM word address for the half-word at screen position w
    function automatic logic [rom_aw-1:0] word_addr(input logic [2:0] w);
        logic [2:0]        sw;
        logic [code_w-1:0] tile;
        sw = hflip_q ? last_word - w : w;  // mirrored walk starts at the right
        case (size_q)
            size_16: tile = code_q + code_w'(sw[2:1]) + code_w'({row_q[4:3], 1'b0});
            size_32: tile = code_q + code_w'(sw[2:1]) + code_w'({row_q[4:3], 2'b00});
            default: tile = code_q;
        endcase
        return {tile, row_q[2:0], sw[0]};
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            done      <= 1'b1;
            draw_half <= 1'b0;
            rom_cs    <= 1'b0;
            line_we   <= 1'b0;
            hb_l      <= 1'b0;
            idx       <= 7'd0;
            base      <= '0;
            word_cnt  <= 3'd0;
            nib_cnt   <= 2'd0;
        end else begin
            hb_l <= hb;
            if (line_start) begin
                cfg_q     <= cfg;
                draw_half <= ~draw_half;  // other half goes to readout
                done      <= 1'b0;
                rom_cs    <= 1'b0;
                line_we   <= 1'b0;
                idx       <= 7'd0;
                base      <= '0;
                state     <= st_next;
            end else begin
                case (state)
                    st_next: begin
                        if (!cfg_q.enable || idx >= cfg_q.obj_count) begin
                            done  <= 1'b1;
                            state <= st_idle;
                        end else begin
                            state <= st_size;
                        end
                    end
                    st_size: begin
                        x8_q           <= scan_data[0];
                        size_q         <= obj_size_e'(scan_data[2:1]);
                        hflip_q        <= scan_data[4];
                        vflip_q        <= scan_data[5];
                        code_q[13:12]  <= scan_data[7:6];
                        code_q[1:0]    <= 2'b00;  // tile offsets fill these
                        state          <= st_ypos;
                    end
                    st_ypos: begin
                        if (miss) begin
                            idx   <= idx + 7'd1;
                            base  <= base + attr_aw'(entry_bytes);
                            state <= st_next;
                        end else begin
                            row_q <= row_diff[4:0] ^ (vflip_q ? height_m1 : 5'd0);
                            state <= st_code;
                        end
                    end
                    st_code: begin
                        code_q[9:2] <= scan_data;
                        state       <= st_colour;
                    end
                    st_colour: begin
                        code_q[11:10] <= scan_data[1:0];
                        pal_q         <= scan_data[7:4];
                        state         <= st_xpos;
                    end
                    st_xpos: begin
                        xpos     <= {x8_q, scan_data} + cfg_q.hoffset;  // wraps at 512
                        word_cnt <= 3'd0;
                        rom_addr <= word_addr(3'd0);
                        rom_cs   <= 1'b1;
                        state    <= st_fetch;
                    end
                    st_fetch: begin
                        if (rom_ok) begin  // waits here as long as the ROM needs
                            pix_data <= rom_data;
                            rom_cs   <= 1'b0;
                            nib_cnt  <= 2'd0;
                            state    <= st_dump;
                        end
                    end
                    st_dump: begin
                        line_we  <= 1'b1;
                        wr_addr  <= xpos;
                        wr_data  <= {pal_q, hflip_q ? pix_data[3:0] : pix_data[15:12]};
                        pix_data <= hflip_q ? pix_data >> 4 : pix_data << 4;
                        xpos     <= xpos + 9'd1;
                        nib_cnt  <= nib_cnt + 2'd1;
                        if (nib_cnt == 2'd3) begin
                            state <= st_step;
                        end
                    end
                    st_step: begin
                        line_we <= 1'b0;
                        if (word_cnt == last_word) begin
                            idx   <= idx + 7'd1;
                            base  <= base + attr_aw'(entry_bytes);
                            state <= st_next;
                        end else begin
                            word_cnt <= word_cnt + 3'd1;
                            rom_addr <= word_addr(word_cnt + 3'd1);
                            rom_cs   <= 1'b1;
                            state    <= st_fetch;
                        end
                    end
                    default: begin
                        line_we <= 1'b0;  // idle until the next line
                    end
                endcase
            end
        end
    end

    assign line_wr = '{we: line_we, half: draw_half, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

//--- design/obj_line_buffer.sv
// Double line buffer. The engine draws into one half while the other
// half is read out pixel by pixel, each location cleared as it is read.
// Pixel value 0 is transparent and leaves the stored byte untouched.
`timescale 1ns/1ps
`default_nettype none

module obj_line_buffer
    import obj_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire line_wr_t   line_wr,
    input  wire logic       draw_half,
    input  wire logic [8:0] hdump,
    input  wire logic       pxl_cen,
    output logic [7:0]      pxl
);

    logic       rd_half;
    logic       opaque;
    wire  [7:0] rd_byte [2];

    assign rd_half = ~draw_half;
    assign opaque  = line_wr.data[3:0] != 4'd0;

    for (genvar h = 0; h < 2; h++) begin : g_half
        logic [7:0] mem [line_w];

        initial begin
            for (int i = 0; i < line_w; i++) begin
                mem[i] = 8'd0;  // blank at power-up
            end
        end

        assign rd_byte[h] = mem[hdump];

        always_ff @(posedge clk) begin
            if (pxl_cen && rd_half == 1'(h)) begin
                mem[hdump] <= 8'd0;  // erase behind the readout
            end else if (line_wr.we && line_wr.half == 1'(h) && opaque) begin
                mem[line_wr.addr] <= line_wr.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pxl <= 8'd0;
        end else if (pxl_cen) begin
            pxl <= rd_byte[rd_half];
        end
    end

endmodule

`default_nettype wire

//--- design/obj_video.sv
// Sprite line renderer top level. Connects the entry table, the control
// registers, the draw engine and the line buffer. Video timing, the
// graphics ROM and the CPU writes come from outside.
`timescale 1ns/1ps
`default_nettype none

module obj_video
    import obj_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire cpu_wr_t           attr_wr,
    input  wire cpu_wr_t           reg_wr,
    input  wire logic              hb,
    input  wire logic              vb,
    input  wire logic [8:0]        vrender,
    input  wire logic [8:0]        hdump,
    input  wire logic              pxl_cen,
    output logic                   rom_cs,
    output logic [rom_aw-1:0]      rom_addr,
    input  wire logic              rom_ok,
    input  wire logic [15:0]       rom_data,
    output logic [7:0]             pxl,
    output logic                   done
);

    obj_cfg_t           cfg;
    logic [attr_aw-1:0] scan_addr;
    logic [7:0]         scan_data;
    line_wr_t           line_wr;
    logic               draw_half;

    obj_attr_ram u_attr (
        .clk       (clk),
        .attr_wr   (attr_wr),
        .scan_addr (scan_addr),
        .scan_data (scan_data)
    );

    obj_ctrl_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .reg_wr (reg_wr),
        .cfg    (cfg)
    );

    obj_line_draw u_draw (
        .clk       (clk),
        .rst       (rst),
        .hb        (hb),
        .vb        (vb),
        .vrender   (vrender),
        .cfg       (cfg),
        .scan_addr (scan_addr),
        .scan_data (scan_data),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_ok    (rom_ok),
        .rom_data  (rom_data),
        .line_wr   (line_wr),
        .draw_half (draw_half),
        .done      (done)
    );

    obj_line_buffer u_line (
        .clk       (clk),
        .rst       (rst),
        .line_wr   (line_wr),
        .draw_half (draw_half),
        .hdump     (hdump),
        .pxl_cen   (pxl_cen),
        .pxl       (pxl)
    );

endmodule

`default_nettype wire

//--- test/obj_ref_model.svh
// Reference side of the sprite renderer testbench: graphics ROM contents,
// the expected line built from the entry rules, the LFSR and the compares.
// Included inside the testbench module after its error counters.

typedef struct packed {
    logic [7:0]  y;
    logic [8:0]  x;
    obj_size_e   size;
    logic        hflip;
    logic        vflip;
    logic [13:0] code;   // low two bits stay 0
    logic [3:0]  pal;
} sprite_t;

logic [31:0] lfsr_state = 32'h0cd49a26;
logic [7:0]  exp_line [line_w];

// taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);  // one step per bit
        r = (r << 1) | int'(lfsr_state[0]);
    end
    return r;
endfunction

function automatic logic [15:0] rom_word(input logic [rom_aw-1:0] a);
    logic [31:0] p;
    p = 32'(a) * 32'h9e37;
    return p[15:0] ^ a[15:0];
endfunction

// later entries are applied last so they win where opaque
task automatic build_expected(input obj_cfg_t cfg, input logic [8:0] vr,
                              input sprite_t [3:0] spr);
    sprite_t     s;
    int          h;
    int          row;
    int          words;
    int          sw;
    int          tile;
    int          x;
    logic [15:0] w_data;
    logic [3:0]  nib;
    for (int i = 0; i < line_w; i++) begin
        exp_line[i] = 8'd0;
    end
    for (int e = 0; e < 4 && e < cfg.obj_count && cfg.enable; e++) begin
        s = spr[e];
        h = 8 << s.size;
        if (vr >= s.y && vr < s.y + h) begin
            row = vr - s.y;
            if (s.vflip) begin
                row = h - 1 - row;
            end
            words = h / 4;  // four pixels per word
            for (int w = 0; w < words; w++) begin
                sw     = s.hflip ? words - 1 - w : w;
                tile   = s.code + sw / 2 + (row / 8) * (h / 8);
                w_data = rom_word(rom_aw'(tile * 16 + (row % 8) * 2 + sw % 2));
                for (int p = 0; p < 4; p++) begin
                    nib = s.hflip ? w_data[4*p +: 4] : w_data[12 - 4*p +: 4];
                    x   = (s.x + cfg.hoffset + 4 * w + p) % line_w;
                    if (nib != 4'd0) begin
                        exp_line[x] = {s.pal, nib};
                    end
                end
            end
        end
    end
endtask

task automatic compare_pixel(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("CHECK FAILED %s: expected %02h actual %02h", name, expected, actual);
    end
endtask

task automatic compare_done_ok(input string name, input bit expected, input bit actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("CHECK FAILED %s: expected %0b actual %0b", name, expected, actual);
    end
endtask

//--- test/obj_video_tb.sv
// Testbench for the sprite line renderer. Each table row loads the entry
// table and registers, renders a line, then reads the finished half back
// through the pixel port and compares it with the reference model.
// The graphics ROM is modelled here with a random response latency.
`timescale 1ns/1ps
`default_nettype none

module obj_video_tb
    import obj_pkg::*;
();

    localparam int n_rows      = 6;
    localparam int watchdog_ns = n_rows * 40000;
    localparam int done_limit  = 2000;  // cycles per line

    logic              clk = 1'b0;
    logic              rst;
    cpu_wr_t           attr_wr;
    cpu_wr_t           reg_wr;
    logic              hb;
    logic              vb;
    logic [8:0]        vrender;
    logic [8:0]        hdump;
    logic              pxl_cen;
    logic              rom_cs;
    logic [rom_aw-1:0] rom_addr;
    logic              rom_ok   = 1'b0;
    logic [15:0]       rom_data = 16'd0;
    logic [7:0]        pxl;
    logic              done;
    logic              rom_busy = 1'b0;
    logic [1:0]        rom_wait = 2'd0;
    int                errors   = 0;
    int                checks   = 0;

    `include "obj_ref_model.svh"

    typedef struct packed {
        obj_cfg_t      cfg;
        logic [8:0]    vrender;
        sprite_t [3:0] spr;
    } scenario_t;

    scenario_t rows [n_rows];
    string     row_name [n_rows] = '{"sizes", "disabled", "miss_count", "flips",
                                     "overlap_wrap", "erase"};

    obj_video uut (
        .clk(clk), .rst(rst), .attr_wr(attr_wr), .reg_wr(reg_wr),
        .hb(hb), .vb(vb), .vrender(vrender), .hdump(hdump), .pxl_cen(pxl_cen),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_ok(rom_ok), .rom_data(rom_data),
        .pxl(pxl), .done(done)
    );

    always #20 clk = ~clk;

    // graphics ROM, answers each request after 1 to 4 cycles
    always @(posedge clk) begin
        if (rst || rom_ok) begin
            rom_ok   <= 1'b0;
            rom_busy <= 1'b0;
        end else if (rom_busy && rom_wait == 2'd0) begin
            rom_ok   <= 1'b1;
            rom_data <= rom_word(rom_addr);
        end else if (rom_busy) begin
            rom_wait <= rom_wait - 2'd1;
        end else if (rom_cs) begin
            rom_busy <= 1'b1;
            rom_wait <= 2'(rand_bits(2));
        end
    end

    initial begin
        #watchdog_ns;
        $display("watchdog expired before all scenarios finished");
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic cpu_write(input bit to_regs, input int addr, input logic [7:0] data);
        @(posedge clk);
        attr_wr <= '{we: !to_regs, addr: 9'(addr), data: data};
        reg_wr  <= '{we: to_regs, addr: 9'(addr), data: data};
    endtask

    task automatic load_row(input scenario_t sc);
        sprite_t s;
        int      a;
        for (int e = 0; e < 4; e++) begin
            s = sc.spr[e];
            a = e * entry_bytes;
            cpu_write(1'b0, a + byte_code_lo, s.code[9:2]);
            cpu_write(1'b0, a + byte_code_hi, {s.pal, 2'b00, s.code[11:10]});
            cpu_write(1'b0, a + byte_ypos, s.y);
            cpu_write(1'b0, a + byte_xpos, s.x[7:0]);
            cpu_write(1'b0, a + byte_attr,
                      {s.code[13:12], s.vflip, s.hflip, 1'b0, s.size, s.x[8]});
        end
        cpu_write(1'b1, reg_enable, 8'(sc.cfg.enable));
        cpu_write(1'b1, reg_count, 8'(sc.cfg.obj_count));
        cpu_write(1'b1, reg_hoff_lo, sc.cfg.hoffset[7:0]);
        cpu_write(1'b1, reg_hoff_hi, 8'(sc.cfg.hoffset[8]));
        @(posedge clk);
        attr_wr <= '0;
        reg_wr  <= '0;
        vrender <= sc.vrender;
    endtask

    task automatic start_line();
        @(posedge clk);
        hb <= 1'b1;  // rising edge of hb marks the line start
        @(posedge clk);
        hb <= 1'b0;
    endtask

    task automatic wait_done(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done && waited < done_limit) begin
            @(negedge clk);
            waited++;
        end
        compare_done_ok({name, " done"}, 1'b1, done);
    endtask

    // one address per cycle, pixel i shows up the cycle after
    task automatic read_line(input string name);
        for (int i = 0; i <= line_w; i++) begin
            @(posedge clk);
            hdump   <= 9'(i);
            pxl_cen <= (i < line_w);
            if (i > 0) begin
                @(negedge clk);
                compare_pixel($sformatf("%s px %0d", name, i - 1), exp_line[i - 1], pxl);
            end
        end
    endtask

    task automatic build_table();
        rows[0]        = '{'{1'b1, 7'd3, 9'd0}, 9'd40, '0};
        rows[0].spr[0] = '{8'd36, 9'd10, size_8, 1'b0, 1'b0, 14'h0010, 4'd1};
        rows[0].spr[1] = '{8'd30, 9'd60, size_16, 1'b0, 1'b0, 14'h0104, 4'd2};
        rows[0].spr[2] = '{8'd20, 9'd120, size_32, 1'b0, 1'b0, 14'h2ea8, 4'd3};
        rows[1]            = rows[0];
        rows[1].cfg.enable = 1'b0;
        rows[2]        = '{'{1'b1, 7'd2, 9'd0}, 9'd100, '0};
        rows[2].spr[0] = '{8'd200, 9'd30, size_32, 1'b0, 1'b0, 14'h0300, 4'd5};
        rows[2].spr[1] = '{8'd92, 9'd80, size_8, 1'b0, 1'b0, 14'h0014, 4'd6};  // ends one line up
        rows[2].spr[2] = '{8'd96, 9'd130, size_16, 1'b0, 1'b0, 14'h0020, 4'd7};
        rows[2].spr[3] = '{8'd100, 9'd180, size_8, 1'b0, 1'b0, 14'h0024, 4'd8};
        rows[3]        = '{'{1'b1, 7'd4, 9'd0}, 9'd50, '0};
        rows[3].spr[0] = '{8'd45, 9'd20, size_16, 1'b1, 1'b0, 14'h0040, 4'd4};
        rows[3].spr[1] = '{8'd30, 9'd100, size_32, 1'b0, 1'b1, 14'h1c80, 4'd5};
        rows[3].spr[2] = '{8'd40, 9'd200, size_16, 1'b1, 1'b1, 14'h00c4, 4'd6};
        rows[3].spr[3] = '{8'd47, 9'd300, size_8, 1'b1, 1'b1, 14'h01fc, 4'd9};
        rows[4]        = '{'{1'b1, 7'd4, 9'd300}, 9'd10, '0};
        rows[4].spr[0] = '{8'd0, 9'd200, size_32, 1'b0, 1'b0, 14'h0100, 4'd10};
        rows[4].spr[1] = '{8'd5, 9'd210, size_16, 1'b0, 1'b1, 14'h0200, 4'd11};
        rows[4].spr[2] = '{8'd8, 9'd212, size_8, 1'b1, 1'b0, 14'h03f8, 4'd12};
        rows[4].spr[3] = '{8'd4, 9'd500, size_8, 1'b0, 1'b0, 14'h0004, 4'd13};
        rows[5]            = rows[4];
        rows[5].cfg.enable = 1'b0;  // half read in the row before must come back blank
    endtask

    initial begin
        rst     = 1'b1;
        attr_wr = '0;
        reg_wr  = '0;
        hb      = 1'b0;
        vb      = 1'b1;
        vrender = 9'd0;
        hdump   = 9'd0;
        pxl_cen = 1'b0;
        build_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_done_ok("reset", 1'b1, done);
        compare_pixel("reset", 8'd0, pxl);
        checks++;
        if (rom_cs !== 1'b0) begin
            errors++;
            $display("CHECK FAILED reset rom_cs: expected 0 actual %0b", rom_cs);
        end
        for (int r = 0; r < n_rows; r++) begin
            build_expected(rows[r].cfg, rows[r].vrender, rows[r].spr);
            load_row(rows[r]);
            start_line();
            wait_done(row_name[r]);
            start_line();  // drawn half moves to readout
            read_line(row_name[r]);
            wait_done(row_name[r]);
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
design/obj_pkg.sv
design/obj_attr_ram.sv
design/obj_ctrl_regs.sv
design/obj_line_draw.sv
design/obj_line_buffer.sv
design/obj_video.sv
+incdir+test
test/obj_video_tb.sv
